// ==== logic/exec_pkg.sv ====
package exec_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Data path width
    localparam int xlen = 32;

    // Register index width, x0..x31
    localparam int reg_addr_w = 5;

    // Shift-and-add steps, one per multiplier bit
    localparam int mul_iters = 32;

    //////////////////////////////
    // Operation encoding
    //////////////////////////////

    // Upper two bits group the ops
    // 00/01 integer ALU, 10 branch compare, 11 multiplier
    typedef enum logic [4:0] {
        op_add   = 5'b00000,
        op_sub   = 5'b00001,
        op_and   = 5'b00010,
        op_or    = 5'b00011,
        op_xor   = 5'b00100,
        op_sll   = 5'b00101,
        op_srl   = 5'b00110,
        op_sra   = 5'b00111,
        op_slt   = 5'b01000,
        op_sltu  = 5'b01001,
        // Pass operand b through, used for lui
        op_lui   = 5'b01010,
        // Branch compares
        op_beq   = 5'b10000,
        op_bne   = 5'b10001,
        op_blt   = 5'b10100,
        op_bge   = 5'b10101,
        op_bltu  = 5'b10110,
        op_bgeu  = 5'b10111,
        // Iterative multiplier
        op_mul   = 5'b11000,
        op_mulhu = 5'b11001
    } alu_op_t;

    // Multiplier FSM states
    typedef enum logic [1:0] {
        mul_idle,
        mul_run,
        mul_done
    } mul_state_t;

endpackage

// ==== logic/operand_forward.sv ====
module operand_forward (
    // Decode side
    input  logic [exec_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [exec_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [exec_pkg::xlen-1:0]       id_rs1_data,
    input  logic [exec_pkg::xlen-1:0]       id_rs2_data,
    input  logic [exec_pkg::xlen-1:0]       id_imm,
    input  logic [exec_pkg::xlen-1:0]       id_pc,
    input  logic                            id_use_imm,
    input  logic                            id_use_pc,
    // Bypass from our own EX/MEM register
    input  logic                            fwd_valid,
    input  logic                            fwd_regwrite,
    input  logic [exec_pkg::reg_addr_w-1:0] fwd_rd,
    input  logic [exec_pkg::xlen-1:0]       fwd_res,
    // Bypass from write-back
    input  logic [exec_pkg::reg_addr_w-1:0] wb_rd,
    input  logic                            wb_regwrite,
    input  logic [exec_pkg::xlen-1:0]       wb_res,
    // Selected operands
    output logic [exec_pkg::xlen-1:0]       op_a,
    output logic [exec_pkg::xlen-1:0]       op_b,
    output logic [exec_pkg::xlen-1:0]       store_data
);
    import exec_pkg::*;

    logic            ex_src_ok;
    logic            wb_src_ok;
    logic            ex_hit_rs1;
    logic            ex_hit_rs2;
    logic            wb_hit_rs1;
    logic            wb_hit_rs2;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    //////////////////////////////
    // Bypass match
    //////////////////////////////

    // A source may forward only if it writes a real register, never x0
    assign ex_src_ok = fwd_valid && fwd_regwrite && (fwd_rd != '0);
    assign wb_src_ok = wb_regwrite && (wb_rd != '0);

    assign ex_hit_rs1 = ex_src_ok && (fwd_rd == id_rs1);
    assign ex_hit_rs2 = ex_src_ok && (fwd_rd == id_rs2);
    assign wb_hit_rs1 = wb_src_ok && (wb_rd == id_rs1);
    assign wb_hit_rs2 = wb_src_ok && (wb_rd == id_rs2);

    // Younger EX/MEM value beats write-back
    assign rs1_val = ex_hit_rs1 ? fwd_res :
                     wb_hit_rs1 ? wb_res  : id_rs1_data;
    assign rs2_val = ex_hit_rs2 ? fwd_res :
                     wb_hit_rs2 ? wb_res  : id_rs2_data;

    //////////////////////////////
    // Operand select
    //////////////////////////////

    // PC in for auipc style ops, immediate in for I-type
    assign op_a = id_use_pc  ? id_pc  : rs1_val;
    assign op_b = id_use_imm ? id_imm : rs2_val;

    // Stores always take the register value
    assign store_data = rs2_val;

endmodule

// ==== logic/int_alu.sv ====
module int_alu (
    input  exec_pkg::alu_op_t         op,
    input  logic [exec_pkg::xlen-1:0] a,
    input  logic [exec_pkg::xlen-1:0] b,
    output logic [exec_pkg::xlen-1:0] result,
    output logic                      comp_res
);
    import exec_pkg::*;

    logic [$clog2(xlen)-1:0] shamt;
    logic                    is_cmp;
    logic                    eq;
    logic                    lt_s;
    logic                    lt_u;

    // Only the low bits of b count as shift amount
    assign shamt = b[$clog2(xlen)-1:0];

    // Compare group sits at 10 in the top op bits
    assign is_cmp = (op[4:3] == 2'b10);

    // Shared comparator outputs
    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        result   = '0;
        comp_res = 1'b0;
        if (is_cmp) begin
            // Branch compare, result stays zero
            case (op)
                op_beq:  comp_res = eq;
                op_bne:  comp_res = !eq;
                op_blt:  comp_res = lt_s;
                op_bge:  comp_res = !lt_s;
                op_bltu: comp_res = lt_u;
                op_bgeu: comp_res = !lt_u;
                default: comp_res = 1'b0;
            endcase
        end else begin
            case (op)
                op_add:  result = a + b;
                op_sub:  result = a - b;
                op_and:  result = a & b;
                op_or:   result = a | b;
                op_xor:  result = a ^ b;
                // Shifts
                op_sll:  result = a << shamt;
                op_srl:  result = a >> shamt;
                op_sra:  result = $unsigned($signed(a) >>> shamt);
                // Set less than, zero extended flag
                op_slt:  result = {{(xlen-1){1'b0}}, lt_s};
                op_sltu: result = {{(xlen-1){1'b0}}, lt_u};
                // lui, immediate already shifted by decode
                op_lui:  result = b;
                // Multiply ops land here and are taken from the multiplier
                default: result = '0;
            endcase
        end
    end

endmodule

// ==== logic/iter_mul.sv ====
module iter_mul (
    input  logic                      clk,
    input  logic                      reset,
    // Valid mul or mulhu presented
    input  logic                      start,
    input  logic                      high_half,
    input  logic [exec_pkg::xlen-1:0] a,
    input  logic [exec_pkg::xlen-1:0] b,
    // Memory back-pressure, freezes the unit
    input  logic                      hold,
    output logic                      busy,
    output logic                      done,
    output logic [exec_pkg::xlen-1:0] product
);
    import exec_pkg::*;

    mul_state_t                    state;
    mul_state_t                    state_next;
    logic [$clog2(mul_iters)-1:0]  step;
    logic                          last_step;
    logic [2*xlen-1:0]             acc;
    logic [xlen-1:0]               mcand;
    logic                          high_sel;
    logic [xlen:0]                 partial;

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    assign last_step = (step == $bits(step)'(mul_iters - 1));

    always_comb begin
        state_next = state;
        case (state)
            mul_idle: begin
                if (start) begin
                    state_next = mul_run;
                end
            end
            // One shift-add per cycle
            mul_run: begin
                if (last_step) begin
                    state_next = mul_done;
                end
            end
            // Product held until EX/MEM takes it
            mul_done: begin
                state_next = mul_idle;
            end
            default: begin
                state_next = mul_idle;
            end
        endcase
        // Nothing moves under back-pressure
        if (hold) begin
            state_next = state;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mul_idle;
        end else begin
            state <= state_next;
        end
    end

    //////////////////////////////
    // Shift-and-add datapath
    //////////////////////////////

    // Upper half plus multiplicand when the current multiplier bit is set
    assign partial = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk) begin
        if (!hold) begin
            if ((state == mul_idle) && start) begin
                // Multiplier goes in the low half and shifts out LSB first
                acc      <= {{xlen{1'b0}}, b};
                mcand    <= a;
                high_sel <= high_half;
                step     <= '0;
            end else if (state == mul_run) begin
                acc  <= {partial, acc[xlen-1:1]};
                step <= step + 1'b1;
            end
        end
    end

    // Stall request covers the launch cycle too
    assign busy = ((state == mul_idle) && start) || (state == mul_run);
    assign done = (state == mul_done);

    // mulhu returns the upper word
    assign product = high_sel ? acc[2*xlen-1:xlen] : acc[xlen-1:0];

endmodule

// ==== logic/ex_mem_reg.sv ====
module ex_mem_reg (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            hold,
    input  logic                            bubble,
    // Execute results
    input  logic                            valid,
    input  logic [exec_pkg::reg_addr_w-1:0] rd,
    input  logic                            regwrite,
    input  logic                            memread,
    input  logic                            memwrite,
    input  logic [exec_pkg::xlen-1:0]       res,
    input  logic                            comp_res,
    input  logic [exec_pkg::xlen-1:0]       store_data,
    input  logic [exec_pkg::xlen-1:0]       pc,
    // Towards the memory stage
    output logic                            ex_mem_valid,
    output logic [exec_pkg::reg_addr_w-1:0] ex_mem_rd,
    output logic                            ex_mem_regwrite,
    output logic                            ex_mem_memread,
    output logic                            ex_mem_memwrite,
    output logic [exec_pkg::xlen-1:0]       ex_mem_alures,
    output logic                            ex_mem_comp_res,
    output logic [exec_pkg::xlen-1:0]       ex_mem_store_data,
    output logic [exec_pkg::xlen-1:0]       ex_mem_pc
);

    //////////////////////////////
    // Control bits
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem_valid    <= 1'b0;
            ex_mem_regwrite <= 1'b0;
            ex_mem_memread  <= 1'b0;
            ex_mem_memwrite <= 1'b0;
        end else if (!hold) begin
            if (bubble) begin
                // Multiplier still working, push an empty slot
                ex_mem_valid    <= 1'b0;
                ex_mem_regwrite <= 1'b0;
                ex_mem_memread  <= 1'b0;
                ex_mem_memwrite <= 1'b0;
            end else begin
                ex_mem_valid    <= valid;
                // Enables only count for a valid instruction
                ex_mem_regwrite <= valid && regwrite;
                ex_mem_memread  <= valid && memread;
                ex_mem_memwrite <= valid && memwrite;
            end
        end
    end

    // Payload follows the control bits, bubbles leave it as is
    always_ff @(posedge clk) begin
        if (!hold && !bubble) begin
            ex_mem_rd         <= rd;
            ex_mem_alures     <= res;
            ex_mem_comp_res   <= comp_res;
            ex_mem_store_data <= store_data;
            ex_mem_pc         <= pc;
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
module execute_stage (
    input  logic                            clk,
    input  logic                            reset,
    // ID/EX inputs, held by decode while stall is high
    input  logic                            id_valid,
    input  exec_pkg::alu_op_t               id_op,
    input  logic [exec_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [exec_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [exec_pkg::reg_addr_w-1:0] id_rd,
    input  logic [exec_pkg::xlen-1:0]       id_rs1_data,
    input  logic [exec_pkg::xlen-1:0]       id_rs2_data,
    input  logic [exec_pkg::xlen-1:0]       id_imm,
    input  logic [exec_pkg::xlen-1:0]       id_pc,
    input  logic                            id_use_imm,
    input  logic                            id_use_pc,
    input  logic                            id_regwrite,
    input  logic                            id_memread,
    input  logic                            id_memwrite,
    // Write-back bypass
    input  logic [exec_pkg::reg_addr_w-1:0] wb_rd,
    input  logic                            wb_regwrite,
    input  logic [exec_pkg::xlen-1:0]       wb_res,
    // Memory back-pressure
    input  logic                            mem_hold,
    output logic                            stall,
    // EX/MEM register
    output logic                            ex_mem_valid,
    output logic [exec_pkg::reg_addr_w-1:0] ex_mem_rd,
    output logic                            ex_mem_regwrite,
    output logic                            ex_mem_memread,
    output logic                            ex_mem_memwrite,
    output logic [exec_pkg::xlen-1:0]       ex_mem_alures,
    output logic                            ex_mem_comp_res,
    output logic [exec_pkg::xlen-1:0]       ex_mem_store_data,
    output logic [exec_pkg::xlen-1:0]       ex_mem_pc
);
    import exec_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] alu_res;
    logic            alu_comp;
    logic            is_mul;
    logic            mul_busy;
    logic            mul_done;
    logic [xlen-1:0] mul_product;
    logic [xlen-1:0] ex_res;
    logic            ex_valid;

    //////////////////////////////
    // Input side
    //////////////////////////////

    operand_forward operand_forward_inst (
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_rs1_data  (id_rs1_data),
        .id_rs2_data  (id_rs2_data),
        .id_imm       (id_imm),
        .id_pc        (id_pc),
        .id_use_imm   (id_use_imm),
        .id_use_pc    (id_use_pc),
        .fwd_valid    (ex_mem_valid),
        .fwd_regwrite (ex_mem_regwrite),
        .fwd_rd       (ex_mem_rd),
        .fwd_res      (ex_mem_alures),
        .wb_rd        (wb_rd),
        .wb_regwrite  (wb_regwrite),
        .wb_res       (wb_res),
        .op_a         (op_a),
        .op_b         (op_b),
        .store_data   (store_data)
    );

    //////////////////////////////
    // Processing
    //////////////////////////////

    int_alu int_alu_inst (
        .op       (id_op),
        .a        (op_a),
        .b        (op_b),
        .result   (alu_res),
        .comp_res (alu_comp)
    );

    assign is_mul = (id_op == op_mul) || (id_op == op_mulhu);

    // Operands latched on launch, so EX/MEM bypass is caught in time
    iter_mul iter_mul_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (id_valid && is_mul),
        .high_half (id_op == op_mulhu),
        .a         (op_a),
        .b         (op_b),
        .hold      (mem_hold),
        .busy      (mul_busy),
        .done      (mul_done),
        .product   (mul_product)
    );

    // Product replaces the ALU result for multiplies
    assign ex_res = is_mul ? mul_product : alu_res;

    // A multiply only counts once its product is ready
    assign ex_valid = id_valid && (!is_mul || mul_done);

    // Back-pressure or a running multiply holds decode
    assign stall = mem_hold || mul_busy;

    //////////////////////////////
    // Output side
    //////////////////////////////

    ex_mem_reg ex_mem_reg_inst (
        .clk               (clk),
        .reset             (reset),
        .hold              (mem_hold),
        .bubble            (mul_busy),
        .valid             (ex_valid),
        .rd                (id_rd),
        .regwrite          (id_regwrite),
        .memread           (id_memread),
        .memwrite          (id_memwrite),
        .res               (ex_res),
        .comp_res          (alu_comp),
        .store_data        (store_data),
        .pc                (id_pc),
        .ex_mem_valid      (ex_mem_valid),
        .ex_mem_rd         (ex_mem_rd),
        .ex_mem_regwrite   (ex_mem_regwrite),
        .ex_mem_memread    (ex_mem_memread),
        .ex_mem_memwrite   (ex_mem_memwrite),
        .ex_mem_alures     (ex_mem_alures),
        .ex_mem_comp_res   (ex_mem_comp_res),
        .ex_mem_store_data (ex_mem_store_data),
        .ex_mem_pc         (ex_mem_pc)
    );

endmodule

// ==== testbench/execute_tb.sv ====
module execute_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import exec_pkg::*;

    //////////////////////////////
    // Run length
    //////////////////////////////

    localparam int alu_reps  = 4;
    localparam int fwd_count = 80;
    localparam int mul_count = 8;
    localparam int bp_count  = 40;
    localparam int n_instr   = 17 * alu_reps + fwd_count + mul_count + bp_count;
    // Every slot as long as a multiply and doubled for back-pressure
    localparam int timeout_cycles = n_instr * (mul_iters + 2) * 2 + 50;
    // valid, rd, three enables, compare, result, store data, pc
    localparam int vec_w = 10 + 3 * xlen;

    logic                  clk;
    logic                  reset;
    logic                  id_valid;
    alu_op_t               id_op;
    logic [reg_addr_w-1:0] id_rs1;
    logic [reg_addr_w-1:0] id_rs2;
    logic [reg_addr_w-1:0] id_rd;
    logic [xlen-1:0]       id_rs1_data;
    logic [xlen-1:0]       id_rs2_data;
    logic [xlen-1:0]       id_imm;
    logic [xlen-1:0]       id_pc;
    logic                  id_use_imm;
    logic                  id_use_pc;
    logic                  id_regwrite;
    logic                  id_memread;
    logic                  id_memwrite;
    logic [reg_addr_w-1:0] wb_rd;
    logic                  wb_regwrite;
    logic [xlen-1:0]       wb_res;
    logic                  mem_hold;
    logic                  stall;
    logic                  ex_mem_valid;
    logic [reg_addr_w-1:0] ex_mem_rd;
    logic                  ex_mem_regwrite;
    logic                  ex_mem_memread;
    logic                  ex_mem_memwrite;
    logic [xlen-1:0]       ex_mem_alures;
    logic                  ex_mem_comp_res;
    logic [xlen-1:0]       ex_mem_store_data;
    logic [xlen-1:0]       ex_mem_pc;

    integer                seed = 32'hea97;
    int                    cycle_count = 0;
    string                 test_name = "reset";
    // What the last rising edge saw
    logic                  edge_stall;
    logic                  edge_hold;
    // Model of the EX/MEM bypass source
    logic                  fwd_live;
    logic [reg_addr_w-1:0] fwd_rd;
    logic [xlen-1:0]       fwd_res;
    logic [vec_w-1:0]      frozen;
    logic [vec_w-1:0]      out_vec;
    logic [vec_w-1:0]      exp_q [$];

    alu_op_t op_list [0:18] = '{op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl,
        op_sra, op_slt, op_sltu, op_lui, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_mul, op_mulhu};

    execute_stage execute_stage_inst (.*);

    assign out_vec = {ex_mem_valid, ex_mem_rd, ex_mem_regwrite, ex_mem_memread,
                      ex_mem_memwrite, ex_mem_comp_res, ex_mem_alures, ex_mem_store_data,
                      ex_mem_pc};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            abort_run("Timeout, the stage stopped making progress");
        end
    end

    // Back-pressure must always reach decode
    assert property (@(posedge clk) disable iff (reset) mem_hold |-> stall)
        else abort_run("stall was low while mem_hold was high");

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic report_mismatch(input string what, input logic [vec_w-1:0] expected,
                                   input logic [vec_w-1:0] actual);
        $display("ERROR %s %s expected %h actual %h", test_name, what, expected, actual);
        $display("TB FAILED");
        $fatal(1, "Stopping at the first failed check");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Stopping at the first failed check");
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [xlen-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic rand_bit();
        logic [xlen-1:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // EX/MEM first, then write-back, then decode
    // x0 is never bypassed
    function automatic logic [xlen-1:0] pick_source(input logic [reg_addr_w-1:0] idx,
                                                   input logic [xlen-1:0] dec,
                                                   input logic ex_on);
        if (ex_on && fwd_live && fwd_rd != 0 && fwd_rd == idx) begin
            return fwd_res;
        end
        if (wb_regwrite && wb_rd != 0 && wb_rd == idx) begin
            return wb_res;
        end
        return dec;
    endfunction

    // Returns {compare flag, result}
    function automatic logic [xlen:0] alu_model(input alu_op_t op, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        logic [$clog2(xlen)-1:0] sh;
        logic [2*xlen-1:0]       wide;
        logic [2*xlen-1:0]       prod;
        logic                    lt_s;
        sh   = b[$clog2(xlen)-1:0];
        // Sign fill from the upper word
        wide = {{xlen{a[xlen-1]}}, a} >> sh;
        prod = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
        lt_s = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b);
        case (op)
            op_add:   return {1'b0, a + b};
            op_sub:   return {1'b0, a - b};
            op_and:   return {1'b0, a & b};
            op_or:    return {1'b0, a | b};
            op_xor:   return {1'b0, a ^ b};
            op_sll:   return {1'b0, a << sh};
            op_srl:   return {1'b0, a >> sh};
            op_sra:   return {1'b0, wide[xlen-1:0]};
            op_slt:   return {1'b0, {(xlen-1){1'b0}}, lt_s};
            op_sltu:  return {1'b0, {(xlen-1){1'b0}}, a < b};
            op_lui:   return {1'b0, b};
            op_beq:   return {a == b, {xlen{1'b0}}};
            op_bne:   return {a != b, {xlen{1'b0}}};
            op_blt:   return {lt_s, {xlen{1'b0}}};
            op_bge:   return {!lt_s, {xlen{1'b0}}};
            op_bltu:  return {a < b, {xlen{1'b0}}};
            op_bgeu:  return {a >= b, {xlen{1'b0}}};
            op_mul:   return {1'b0, prod[xlen-1:0]};
            op_mulhu: return {1'b0, prod[2*xlen-1:xlen]};
            default:  return '0;
        endcase
    endfunction

    //////////////////////////////
    // Cycle and check
    //////////////////////////////

    task automatic check_reset_state();
        assert (!ex_mem_valid && !ex_mem_regwrite && !ex_mem_memread && !ex_mem_memwrite
                && !stall)
            else report_mismatch("control low", '0, {ex_mem_valid, ex_mem_regwrite,
                                 ex_mem_memread, ex_mem_memwrite, stall});
    endtask

    task automatic check_outputs();
        logic [vec_w-1:0] want;
        if (edge_hold) begin
            assert (out_vec == frozen) else report_mismatch("hold freeze", frozen, out_vec);
        end else if (edge_stall) begin
            // Multiplier bubble
            assert (!ex_mem_valid && !ex_mem_regwrite && !ex_mem_memread && !ex_mem_memwrite)
                else abort_run("EX/MEM held a live slot while the multiplier was busy");
        end else if (ex_mem_valid) begin
            assert (exp_q.size() > 0) else abort_run("EX/MEM showed an instruction never issued");
            want = exp_q.pop_front();
            assert (out_vec == want) else report_mismatch("ex_mem outputs", want, out_vec);
        end
        frozen = out_vec;
    endtask

    task automatic tick();
        @(posedge clk);
        // Stall still shows the value this edge acted on
        edge_stall = stall;
        edge_hold  = mem_hold;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle_cycle();
        id_valid = 1'b0;
        mem_hold = 1'b0;
        tick();
        fwd_live = 1'b0;
    endtask

    // dep picks indices from x0..x3 so bypass paths collide
    task automatic issue(input alu_op_t op, input logic dep, input int hold_level);
        logic [xlen:0]   alu_out;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] sd;
        logic            is_mul;
        int              busy_edges;
        int              exp_busy;
        id_valid    = 1'b1;
        id_op       = op;
        id_rs1      = dep ? rand_word() % 4 : rand_word() % 16;
        id_rs2      = dep ? rand_word() % 4 : rand_word() % 16;
        id_rd       = dep ? rand_word() % 4 : 16 + rand_word() % 16;
        wb_rd       = dep ? rand_word() % 4 : 16 + rand_word() % 16;
        id_rs1_data = rand_word();
        id_rs2_data = rand_word();
        id_imm      = rand_word();
        id_pc       = rand_word();
        id_use_imm  = rand_bit();
        id_use_pc   = rand_bit();
        id_regwrite = rand_bit();
        id_memread  = rand_bit();
        id_memwrite = rand_bit();
        wb_regwrite = rand_bit();
        wb_res      = rand_word();
        is_mul   = (op == op_mul) || (op == op_mulhu);
        exp_busy = is_mul ? mul_iters + 1 : 0;
        a  = id_use_pc ? id_pc : pick_source(id_rs1, id_rs1_data, 1'b1);
        b  = id_use_imm ? id_imm : pick_source(id_rs2, id_rs2_data, 1'b1);
        // Product lands behind bubbles, so store data only sees write-back
        sd = pick_source(id_rs2, id_rs2_data, !is_mul);
        alu_out = alu_model(op, a, b);
        exp_q.push_back({1'b1, id_rd, id_regwrite, id_memread, id_memwrite, alu_out, sd, id_pc});
        busy_edges = 0;
        edge_stall = 1'b1;
        while (edge_stall) begin
            mem_hold = (rand_word() % 8) < hold_level;
            tick();
            if (edge_stall && !edge_hold) begin
                busy_edges++;
            end
        end
        assert (busy_edges == exp_busy)
            else report_mismatch("stall cycles", exp_busy, busy_edges);
        assert (exp_q.size() == 0)
            else abort_run("Result was missing one edge after the stage accepted it");
        fwd_live = id_regwrite;
        fwd_rd   = id_rd;
        fwd_res  = alu_out[xlen-1:0];
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        reset       = 1'b1;
        id_valid    = 1'b0;
        id_op       = op_add;
        id_rs1      = '0;
        id_rs2      = '0;
        id_rd       = '0;
        id_rs1_data = '0;
        id_rs2_data = '0;
        id_imm      = '0;
        id_pc       = '0;
        id_use_imm  = 1'b0;
        id_use_pc   = 1'b0;
        id_regwrite = 1'b0;
        id_memread  = 1'b0;
        id_memwrite = 1'b0;
        wb_rd       = '0;
        wb_regwrite = 1'b0;
        wb_res      = '0;
        mem_hold    = 1'b0;
        fwd_live    = 1'b0;
        fwd_rd      = '0;
        fwd_res     = '0;
        repeat (10) begin
            @(negedge clk);
            check_reset_state();
        end
        reset = 1'b0;
        tick();
        check_reset_state();
        // Every ALU and compare op with sources that never hit a bypass
        test_name = "alu";
        for (int i = 0; i < 17; i++) begin
            repeat (alu_reps) issue(op_list[i], 1'b0, 0);
        end
        idle_cycle();
        test_name = "forward";
        repeat (fwd_count) issue(op_list[rand_word() % 17], 1'b1, 0);
        test_name = "multiply";
        for (int i = 0; i < mul_count; i++) begin
            issue(op_list[17 + (i % 2)], 1'b1, 0);
        end
        // Roughly three cycles in eight held
        test_name = "backpressure";
        repeat (bp_count) issue(op_list[rand_word() % 19], 1'b1, 3);
        // Trailing empty slot catches a duplicated last result
        idle_cycle();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
logic/exec_pkg.sv
logic/operand_forward.sv
logic/int_alu.sv
logic/iter_mul.sv
logic/ex_mem_reg.sv
logic/execute_stage.sv
testbench/execute_tb.sv
